// ==== src/raster_macros.svh ====
`ifndef RASTER_MACROS_SVH
`define RASTER_MACROS_SVH

// Screen coordinate width
`define COORD_W 8

// Doubled delta plus sign
`define ERR_W (`COORD_W + 2)

`endif

// ==== src/raster_geom_pkg.sv ====
`include "raster_macros.svh"

package raster_geom_pkg;

  typedef logic [`COORD_W-1:0] coord_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
  } vertex_t;

  // Absolute extent of an edge along one axis
  typedef logic [`COORD_W-1:0] delta_t;

endpackage

// ==== src/raster_ctrl_pkg.sv ====
`include "raster_macros.svh"

package raster_ctrl_pkg;

  typedef enum logic [2:0] {
    idle,
    setup,
    wait_row,
    walk_upper,
    switch_edge,
    walk_lower,
    finish
  } walk_state_t;

  typedef enum logic {
    sel_upper,
    sel_lower
  } short_sel_t;

endpackage

// ==== src/edge_if.sv ====
`timescale 1ns/100ps
`include "raster_macros.svh"

interface edge_if;

  raster_geom_pkg::coord_t x_start;
  raster_geom_pkg::coord_t y_start;
  raster_geom_pkg::coord_t y_end;   // Last row of the edge
  raster_geom_pkg::delta_t dx;
  raster_geom_pkg::delta_t dy;
  logic                    x_neg;   // x falls as y grows

  modport src (output x_start, y_start, y_end, dx, dy, x_neg);
  modport dst (input x_start, y_start, y_end, dx, dy, x_neg);

endinterface

// ==== src/vertex_setup.sv ====
`timescale 1ns/100ps

module vertex_setup (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       start,
  input  raster_geom_pkg::vertex_t   v0,
  input  raster_geom_pkg::vertex_t   v1,
  input  raster_geom_pkg::vertex_t   v2,
  input  raster_ctrl_pkg::short_sel_t short_sel,
  edge_if.src                        edge_long,
  edge_if.src                        edge_short,
  output logic                       flat_top,
  output logic                       flat_bottom
);

  raster_geom_pkg::vertex_t s0, s1, s2;
  raster_geom_pkg::vertex_t tmp;
  raster_geom_pkg::vertex_t top_q, mid_q, bot_q;
  raster_geom_pkg::vertex_t sa, sb;
  logic                     valid_q;

  // Strict compare keeps ties in input order
  always_comb begin
    s0  = v0;
    s1  = v1;
    s2  = v2;
    tmp = '0;
    if (s0.y > s1.y) begin
      tmp = s0;
      s0  = s1;
      s1  = tmp;
    end
    if (s1.y > s2.y) begin
      tmp = s1;
      s1  = s2;
      s2  = tmp;
    end
    if (s0.y > s1.y) begin
      tmp = s0;
      s0  = s1;
      s1  = tmp;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      top_q <= s0;
      mid_q <= s1;
      bot_q <= s2;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      valid_q <= 1'b0;
    end else if (start) begin
      valid_q <= 1'b1;
    end
  end

  // Short edge endpoints
  assign sa = (short_sel == raster_ctrl_pkg::sel_lower) ? mid_q : top_q;
  assign sb = (short_sel == raster_ctrl_pkg::sel_lower) ? bot_q : mid_q;

  assign edge_long.x_start = top_q.x;
  assign edge_long.y_start = top_q.y;
  assign edge_long.y_end   = bot_q.y;
  assign edge_long.x_neg   = bot_q.x < top_q.x;
  assign edge_long.dx      = edge_long.x_neg ? top_q.x - bot_q.x : bot_q.x - top_q.x;
  assign edge_long.dy      = bot_q.y - top_q.y;

  assign edge_short.x_start = sa.x;
  assign edge_short.y_start = sa.y;
  assign edge_short.y_end   = sb.y;
  assign edge_short.x_neg   = sb.x < sa.x;
  assign edge_short.dx      = edge_short.x_neg ? sa.x - sb.x : sb.x - sa.x;
  assign edge_short.dy      = sb.y - sa.y;

  assign flat_top    = valid_q && (top_q.y == mid_q.y);
  assign flat_bottom = valid_q && (mid_q.y == bot_q.y);

endmodule

// ==== src/edge_walker.sv ====
`timescale 1ns/100ps
`include "raster_macros.svh"

module edge_walker (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    load,
  input  logic                    advance,
  edge_if.dst                     edge_bus,
  output raster_geom_pkg::coord_t x,
  output raster_geom_pkg::coord_t y,
  output logic                    row_reached
);

  raster_geom_pkg::coord_t    row_q;   // Row of last reported point
  logic                       fresh;   // On start row since load
  logic signed [`ERR_W-1:0]   err;
  logic                       steep;
  raster_geom_pkg::delta_t    minor, major;
  logic signed [`ERR_W-1:0]   two_minor, two_major;
  logic signed [`ERR_W-1:0]   err_init;
  logic                       at_end;
  logic                       stepping;
  raster_geom_pkg::coord_t    x_step;

  assign steep     = edge_bus.dy > edge_bus.dx;
  assign minor     = steep ? edge_bus.dx : edge_bus.dy;
  assign major     = steep ? edge_bus.dy : edge_bus.dx;
  assign two_minor = {1'b0, minor, 1'b0};
  assign two_major = {1'b0, major, 1'b0};
  assign err_init  = two_minor - {2'b00, major};

  assign at_end      = y == edge_bus.y_end;
  assign row_reached = fresh || (y != row_q);
  assign stepping    = !row_reached && !at_end;
  assign x_step      = edge_bus.x_neg ? x - 1'b1 : x + 1'b1;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      x     <= '0;
      y     <= '0;
      row_q <= '0;
      fresh <= 1'b0;
      err   <= '0;
    end else if (load) begin
      x     <= edge_bus.x_start;
      y     <= edge_bus.y_start;
      row_q <= edge_bus.y_start;
      fresh <= !advance;   // Load with advance chases the next row
      err   <= err_init;
    end else if (advance && row_reached && !at_end) begin
      row_q <= y;
      fresh <= 1'b0;
    end else if (stepping) begin
      if (err > 0) begin
        x   <= x_step;
        y   <= y + 1'b1;
        err <= err + two_minor - two_major;
      end else begin
        if (steep) begin
          y <= y + 1'b1;
        end else begin
          x <= x_step;
        end
        err <= err + two_minor;
      end
    end
  end

endmodule

// ==== src/span_sequencer.sv ====
`timescale 1ns/100ps

module span_sequencer (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        start,
  input  logic                        next,
  input  logic                        long_row,
  input  logic                        short_row,
  input  logic                        flat_top,
  input  logic                        flat_bottom,
  input  raster_geom_pkg::coord_t     long_x,
  input  raster_geom_pkg::coord_t     short_x,
  input  raster_geom_pkg::coord_t     row_y,
  output logic                        load_long,
  output logic                        load_short,
  output logic                        advance,
  output raster_ctrl_pkg::short_sel_t short_sel,
  output logic                        span_valid,
  output logic                        done,
  output raster_geom_pkg::coord_t     span_xa,
  output raster_geom_pkg::coord_t     span_xb,
  output raster_geom_pkg::coord_t     span_y
);

  raster_ctrl_pkg::walk_state_t state, state_nxt;
  raster_ctrl_pkg::short_sel_t  sel_q;
  logic                         both_row;
  logic                         swap;       // Upper short edge used up
  logic                         walking;
  raster_ctrl_pkg::short_sel_t  first_sel;

  assign both_row  = long_row && short_row;
  assign walking   = (state == raster_ctrl_pkg::walk_upper) ||
                     (state == raster_ctrl_pkg::walk_lower);
  assign first_sel = flat_top ? raster_ctrl_pkg::sel_lower : raster_ctrl_pkg::sel_upper;

  // Probe cycle after advance, only a refused walker still reports its row
  assign swap = (state == raster_ctrl_pkg::switch_edge) && short_row && !long_row &&
                (sel_q == raster_ctrl_pkg::sel_upper) && !flat_bottom;

  assign load_long  = state == raster_ctrl_pkg::setup;
  assign load_short = (state == raster_ctrl_pkg::setup) || swap;
  assign advance    = ((state == raster_ctrl_pkg::wait_row) && next) || swap;

  always_comb begin
    if (state == raster_ctrl_pkg::setup) begin
      short_sel = first_sel;
    end else if (swap) begin
      short_sel = raster_ctrl_pkg::sel_lower;
    end else begin
      short_sel = sel_q;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      raster_ctrl_pkg::idle:     if (start) state_nxt = raster_ctrl_pkg::setup;
      raster_ctrl_pkg::setup:    state_nxt = raster_ctrl_pkg::wait_row;
      raster_ctrl_pkg::wait_row: if (next) state_nxt = raster_ctrl_pkg::switch_edge;
      raster_ctrl_pkg::switch_edge: begin
        if (both_row) begin
          state_nxt = raster_ctrl_pkg::finish;   // Both edges at bottom row
        end else if (swap || sel_q == raster_ctrl_pkg::sel_lower) begin
          state_nxt = raster_ctrl_pkg::walk_lower;
        end else begin
          state_nxt = raster_ctrl_pkg::walk_upper;
        end
      end
      raster_ctrl_pkg::walk_upper,
      raster_ctrl_pkg::walk_lower: if (both_row) state_nxt = raster_ctrl_pkg::wait_row;
      raster_ctrl_pkg::finish:   state_nxt = raster_ctrl_pkg::idle;
      default:                   state_nxt = raster_ctrl_pkg::idle;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state      <= raster_ctrl_pkg::idle;
      sel_q      <= raster_ctrl_pkg::sel_upper;
      span_valid <= 1'b0;
      done       <= 1'b0;
    end else begin
      state      <= state_nxt;
      span_valid <= (state == raster_ctrl_pkg::setup) || (walking && both_row);
      done       <= (state == raster_ctrl_pkg::switch_edge) && both_row;
      if (state == raster_ctrl_pkg::setup) begin
        sel_q <= first_sel;
      end else if (swap) begin
        sel_q <= raster_ctrl_pkg::sel_lower;
      end
    end
  end

  // Walkers hold still until the next accepted request
  assign span_xa = long_x;
  assign span_xb = short_x;
  assign span_y  = row_y;

endmodule

// ==== src/triangle_span_top.sv ====
`timescale 1ns/100ps

module triangle_span_top (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    start,
  input  raster_geom_pkg::coord_t x0,
  input  raster_geom_pkg::coord_t y0,
  input  raster_geom_pkg::coord_t x1,
  input  raster_geom_pkg::coord_t y1,
  input  raster_geom_pkg::coord_t x2,
  input  raster_geom_pkg::coord_t y2,
  input  logic                    next,
  output logic                    span_valid,
  output logic                    done,
  output raster_geom_pkg::coord_t span_xa,
  output raster_geom_pkg::coord_t span_xb,
  output raster_geom_pkg::coord_t span_y
);

  edge_if edge_long ();
  edge_if edge_short ();

  logic                        load_long, load_short, advance;
  logic                        long_row, short_row;
  logic                        flat_top, flat_bottom;
  raster_ctrl_pkg::short_sel_t short_sel;
  raster_geom_pkg::coord_t     long_x, long_y, short_x;

  vertex_setup vertex_setup_inst (
    .clk         (clk),
    .reset_n     (reset_n),
    .start       (start),
    .v0          (raster_geom_pkg::vertex_t'({x0, y0})),
    .v1          (raster_geom_pkg::vertex_t'({x1, y1})),
    .v2          (raster_geom_pkg::vertex_t'({x2, y2})),
    .short_sel   (short_sel),
    .edge_long   (edge_long),
    .edge_short  (edge_short),
    .flat_top    (flat_top),
    .flat_bottom (flat_bottom)
  );

  edge_walker long_walker (
    .clk         (clk),
    .reset_n     (reset_n),
    .load        (load_long),
    .advance     (advance),
    .edge_bus    (edge_long),
    .x           (long_x),
    .y           (long_y),
    .row_reached (long_row)
  );

  edge_walker short_walker (
    .clk         (clk),
    .reset_n     (reset_n),
    .load        (load_short),
    .advance     (advance),
    .edge_bus    (edge_short),
    .x           (short_x),
    .y           (),
    .row_reached (short_row)
  );

  span_sequencer span_sequencer_inst (
    .clk         (clk),
    .reset_n     (reset_n),
    .start       (start),
    .next        (next),
    .long_row    (long_row),
    .short_row   (short_row),
    .flat_top    (flat_top),
    .flat_bottom (flat_bottom),
    .long_x      (long_x),
    .short_x     (short_x),
    .row_y       (long_y),   // Short walker sits on the same row once both reached
    .load_long   (load_long),
    .load_short  (load_short),
    .advance     (advance),
    .short_sel   (short_sel),
    .span_valid  (span_valid),
    .done        (done),
    .span_xa     (span_xa),
    .span_xb     (span_xb),
    .span_y      (span_y)
  );

endmodule

// ==== verif/tb_triangle_span.sv ====
`timescale 1ns/100ps

module tb_triangle_span;

  localparam int NUM_ENTRIES = 4;
  localparam int WAIT_LIMIT  = 1000;   // Cycles per wait
  localparam int MAX_SPANS   = 300;
  // Columns after the six vertex words x0 y0 x1 y1 x2 y2
  localparam int COUNT = 6, FXA = 7, FXB = 8, FY = 9, LXA = 10, LXB = 11, LY = 12, RIGHT = 13;

  logic clk;
  logic reset_n;
  logic start;
  logic next;
  raster_geom_pkg::coord_t x0, y0, x1, y1, x2, y2;
  logic span_valid;
  logic done;
  raster_geom_pkg::coord_t span_xa, span_xb, span_y;

  int stim [NUM_ENTRIES][14];
  int got_xa [MAX_SPANS];
  int got_xb [MAX_SPANS];
  int got_y [MAX_SPANS];
  int ref_xa [MAX_SPANS];
  int ref_xb [MAX_SPANS];
  int ref_y [MAX_SPANS];
  int got_n;
  int ref_n;
  int errors;
  int spans_seen;
  integer seed;

  triangle_span_top triangle_span_top_inst (
    .clk(clk), .reset_n(reset_n), .start(start),
    .x0(x0), .y0(y0), .x1(x1), .y1(y1), .x2(x2), .y2(y2),
    .next(next), .span_valid(span_valid), .done(done),
    .span_xa(span_xa), .span_xb(span_xb), .span_y(span_y)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_mismatch(input string name, input int got, input int exp);
    $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
    errors++;
  endtask

  task automatic report_error(input string msg);
    $display("ERROR: %s", msg);
    errors++;
  endtask

  // Waits for span_valid or done; a disturbed wait adds a late next and a busy start
  task automatic wait_answer(input bit disturb, output bit got_span, output bit got_done,
                             output int lat);
    lat = 0;
    got_span = 1'b0;
    got_done = 1'b0;
    while (!got_span && !got_done && lat < WAIT_LIMIT) begin
      @(posedge clk);
      lat++;
      next  <= disturb && (lat == 1);
      start <= disturb && (lat == 2);
      @(negedge clk);
      got_span = span_valid;
      got_done = done;
    end
    if (!got_span && !got_done) report_error("timeout waiting for span_valid or done");
  endtask

  task automatic run_triangle(input int ax, input int ay, input int bx, input int by,
                              input int cx, input int cy, input bit disturb);
    bit got_span;
    bit got_done;
    int lat;
    got_n = 0;
    @(posedge clk);
    x0 <= 8'(ax);
    y0 <= 8'(ay);
    x1 <= 8'(bx);
    y1 <= 8'(by);
    x2 <= 8'(cx);
    y2 <= 8'(cy);
    start <= 1'b1;
    wait_answer(1'b0, got_span, got_done, lat);
    if (got_span && lat != 2) report_mismatch("span_valid latency", lat, 2);
    if (got_done) report_error("done came before the first span");
    while (got_span && got_n < MAX_SPANS) begin
      got_xa[got_n] = int'(span_xa);
      got_xb[got_n] = int'(span_xb);
      got_y[got_n]  = int'(span_y);
      got_n++;
      @(posedge clk);
      next <= 1'b1;
      wait_answer(disturb, got_span, got_done, lat);
    end
    if (got_n == MAX_SPANS) report_error("span list does not end");
    if (!got_done) report_error("no done pulse after the last span");
    @(posedge clk);
    start <= 1'b0;
    next  <= 1'b0;
    @(negedge clk);
    if (done || span_valid) report_error("strobe still high one cycle after done");
    spans_seen += got_n;
  endtask

  task automatic check_entry(input int i);
    int k;
    int lo;
    int hi;
    lo = 255;
    hi = 0;
    for (k = 0; k < 6; k += 2) begin
      if (stim[i][k] < lo) lo = stim[i][k];
      if (stim[i][k] > hi) hi = stim[i][k];
    end
    if (got_n != stim[i][COUNT]) report_mismatch("span count", got_n, stim[i][COUNT]);
    if (got_n > 0) begin
      if (got_xa[0] != stim[i][FXA]) report_mismatch("first span_xa", got_xa[0], stim[i][FXA]);
      if (got_xb[0] != stim[i][FXB]) report_mismatch("first span_xb", got_xb[0], stim[i][FXB]);
      if (got_y[0] != stim[i][FY]) report_mismatch("first span_y", got_y[0], stim[i][FY]);
      k = got_n - 1;
      if (got_xa[k] != stim[i][LXA]) report_mismatch("last span_xa", got_xa[k], stim[i][LXA]);
      if (got_xb[k] != stim[i][LXB]) report_mismatch("last span_xb", got_xb[k], stim[i][LXB]);
      if (got_y[k] != stim[i][LY]) report_mismatch("last span_y", got_y[k], stim[i][LY]);
    end
    for (k = 0; k < got_n; k++) begin
      if (got_y[k] != got_y[0] + k) report_mismatch("span_y", got_y[k], got_y[0] + k);
      if (got_xa[k] < lo || got_xa[k] > hi) report_mismatch("span_xa in x range", got_xa[k], lo);
      if (got_xb[k] < lo || got_xb[k] > hi) report_mismatch("span_xb in x range", got_xb[k], hi);
      if (stim[i][RIGHT] != 0 && k > 0) begin
        if (got_xa[k] != got_xa[0]) report_mismatch("span_xa", got_xa[k], got_xa[0]);
        // Slope one edge moves exactly one column per row
        if (got_xb[k] - got_xb[k-1] != 1 && got_xb[k-1] - got_xb[k] != 1)
          report_mismatch("span_xb step", got_xb[k], got_xb[k-1] + 1);
      end
    end
  endtask

  task automatic compare_with_reference();
    int k;
    if (got_n != ref_n) report_mismatch("span count", got_n, ref_n);
    for (k = 0; k < got_n && k < ref_n; k++) begin
      if (got_xa[k] != ref_xa[k]) report_mismatch("span_xa", got_xa[k], ref_xa[k]);
      if (got_xb[k] != ref_xb[k]) report_mismatch("span_xb", got_xb[k], ref_xb[k]);
      if (got_y[k] != ref_y[k]) report_mismatch("span_y", got_y[k], ref_y[k]);
    end
  endtask

  initial begin
    int i;
    int k;
    int j;
    int pick;
    int tmp;
    int px [3];
    int py [3];
    seed = 32'h628f_0ea9;
    errors = 0;
    spans_seen = 0;
    // x0 y0 x1 y1 x2 y2, count, first xa xb y, last xa xb y, right triangle
    stim = '{
      '{10, 20, 40, 50, 30, 0, 51, 30, 30, 0, 40, 40, 50, 0},         // General
      '{10, 100, 50, 100, 30, 140, 41, 10, 50, 100, 30, 30, 140, 0},  // Flat top
      '{70, 200, 50, 230, 90, 230, 31, 70, 70, 200, 90, 50, 230, 0},  // Flat bottom
      '{10, 10, 10, 30, 20, 20, 21, 10, 10, 10, 10, 10, 30, 1}        // Vertical long edge
    };
    reset_n <= 1'b0;
    start   <= 1'b0;
    next    <= 1'b0;
    x0 <= '0;
    y0 <= '0;
    x1 <= '0;
    y1 <= '0;
    x2 <= '0;
    y2 <= '0;
    repeat (10) @(posedge clk);
    reset_n <= 1'b1;
    for (k = 0; k < 20; k++) begin   // Quiet while idle
      @(negedge clk);
      if (span_valid) report_mismatch("span_valid", 1, 0);
      if (done) report_mismatch("done", 1, 0);
    end
    for (i = 0; i < NUM_ENTRIES; i++) begin
      run_triangle(stim[i][0], stim[i][1], stim[i][2], stim[i][3], stim[i][4], stim[i][5], 1'b0);
      check_entry(i);
    end
    ref_n = got_n;   // Last entry is the right triangle
    ref_xa = got_xa;
    ref_xb = got_xb;
    ref_y = got_y;
    for (k = 0; k < 3; k++) begin
      px = '{stim[3][0], stim[3][2], stim[3][4]};
      py = '{stim[3][1], stim[3][3], stim[3][5]};
      for (j = 2; j > 0; j--) begin
        pick = int'($unsigned($random(seed)) % (j + 1));
        tmp = px[j];
        px[j] = px[pick];
        px[pick] = tmp;
        tmp = py[j];
        py[j] = py[pick];
        py[pick] = tmp;
      end
      run_triangle(px[0], py[0], px[1], py[1], px[2], py[2], 1'b0);
      compare_with_reference();
    end
    run_triangle(stim[0][0], stim[0][1], stim[0][2], stim[0][3], stim[0][4], stim[0][5], 1'b0);
    ref_n = got_n;
    ref_xa = got_xa;
    ref_xb = got_xb;
    ref_y = got_y;
    run_triangle(stim[0][0], stim[0][1], stim[0][2], stim[0][3], stim[0][4], stim[0][5], 1'b1);
    compare_with_reference();
    $display("errors: %0d, spans checked: %0d", errors, spans_seen);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+src
src/raster_geom_pkg.sv
src/raster_ctrl_pkg.sv
src/edge_if.sv
src/vertex_setup.sv
src/edge_walker.sv
src/span_sequencer.sv
src/triangle_span_top.sv
verif/tb_triangle_span.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the triangle span testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_triangle_span -o tb_triangle_span
./obj_dir/tb_triangle_span | tee sim.log

if grep -q "sim failed" sim.log; then
  exit 1
fi
